// ==== hw/sw_pkg.sv ====
// shared sizes, scoring constants and types for the smith-waterman engine; import into each module
package sw_pkg;

    localparam int REF_MAX_LENGTH  = 16;
    localparam int READ_MAX_LENGTH = 8;
    localparam int SCORE_BITWIDTH  = 10;

    localparam int COL_W   = $clog2(REF_MAX_LENGTH);
    localparam int ROW_W   = $clog2(READ_MAX_LENGTH);
    // must hold ref_len + read_len
    localparam int STEP_W  = $clog2(REF_MAX_LENGTH + READ_MAX_LENGTH + 1);

    typedef logic [1:0]                        base_t;
    typedef logic signed [SCORE_BITWIDTH-1:0]  score_t;
    // first base sits in the top bit pair
    typedef logic [2*REF_MAX_LENGTH-1:0]       ref_seq_t;
    typedef logic [2*READ_MAX_LENGTH-1:0]      read_seq_t;
    typedef logic [COL_W:0]                    ref_len_t;
    typedef logic [ROW_W:0]                    read_len_t;
    typedef logic [COL_W-1:0]                  col_t;
    typedef logic [ROW_W-1:0]                  row_t;
    typedef logic [STEP_W-1:0]                 step_t;

    // substitution and affine gap scores
    localparam score_t MATCH_SCORE    = score_t'(2);
    localparam score_t MISMATCH_SCORE = score_t'(-1);
    localparam score_t GAP_OPEN       = score_t'(-2);
    localparam score_t GAP_EXTEND     = score_t'(-1);

    typedef enum logic [2:0] {
        IDLE,
        LOAD,
        CALC,
        SCAN,
        DONE
    } ctrl_state_t;

endpackage

// ==== hw/sw_pe.sv ====
// one systolic cell; scores one read row against the passing reference bases
`timescale 1ns/1ps

module sw_pe import sw_pkg::*; (
    input  logic    clk,
    input  logic    rst,
    input  base_t   i_base,
    input  base_t   i_read_base,
    input  logic    i_base_valid,
    input  logic    i_row_active,
    input  logic    i_clear,
    input  col_t    i_col,
    input  score_t  i_h_top,
    input  score_t  i_h_diag,
    input  score_t  i_e_top,
    output score_t  o_h,
    output score_t  o_h_prev,
    output score_t  o_e,
    output base_t   o_base,
    output logic    o_base_valid,
    output logic    o_cell_valid,
    output col_t    o_col
);

    score_t f_q;
    score_t sub_score;
    score_t e_new;
    score_t f_new;
    score_t h_new;

    function automatic score_t smax(score_t a, score_t b);
        return (b > a) ? b : a;
    endfunction

    // left neighbour of this cell is this row's own previous result
    always_comb begin
        sub_score = (i_base == i_read_base) ? MATCH_SCORE : MISMATCH_SCORE;
        e_new     = smax(smax(i_h_top + GAP_OPEN, i_e_top + GAP_EXTEND), '0);
        f_new     = smax(smax(o_h + GAP_OPEN, f_q + GAP_EXTEND), '0);
        h_new     = smax(smax(i_h_diag + sub_score, e_new), f_new);
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            o_base_valid <= 1'b0;
            o_cell_valid <= 1'b0;
        end else if (i_clear) begin
            // flush stale bases still travelling down from the last job
            o_base_valid <= 1'b0;
            o_cell_valid <= 1'b0;
        end else begin
            o_base_valid <= i_base_valid;
            o_cell_valid <= i_base_valid && i_row_active;
        end
    end

    always_ff @(posedge clk) begin
        o_base <= i_base;
        o_col  <= i_col;
        if (i_clear) begin
            o_h      <= '0;
            o_h_prev <= '0;
            o_e      <= '0;
            f_q      <= '0;
        end else if (i_base_valid) begin
            o_h      <= h_new;
            o_h_prev <= o_h;
            o_e      <= e_new;
            f_q      <= f_new;
        end
    end

endmodule

// ==== hw/sw_pe_array.sv ====
// read store plus a chain of cells, one per read base; cells on one anti-diagonal run together
`timescale 1ns/1ps

module sw_pe_array import sw_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       i_load,
    input  read_seq_t  i_read_seq,
    input  read_len_t  i_read_len,
    input  base_t      i_base,
    input  logic       i_base_valid,
    input  col_t       i_col,
    output score_t     o_score      [READ_MAX_LENGTH],
    output logic       o_cell_valid [READ_MAX_LENGTH],
    output col_t       o_col        [READ_MAX_LENGTH]
);

    read_seq_t read_q;

    score_t h_prev       [READ_MAX_LENGTH];
    score_t e_q          [READ_MAX_LENGTH];
    base_t  base_q       [READ_MAX_LENGTH];
    logic   base_valid_q [READ_MAX_LENGTH];

    score_t h_top_in     [READ_MAX_LENGTH];
    score_t h_diag_in    [READ_MAX_LENGTH];
    score_t e_top_in     [READ_MAX_LENGTH];
    base_t  base_in      [READ_MAX_LENGTH];
    logic   valid_in     [READ_MAX_LENGTH];
    col_t   col_in       [READ_MAX_LENGTH];
    logic   row_active   [READ_MAX_LENGTH];

    always_ff @(posedge clk) begin
        if (i_load) begin
            read_q <= i_read_seq;
        end
    end

    genvar r;
    generate
        for (r = 0; r < READ_MAX_LENGTH; r++) begin : g_row
            if (r == 0) begin : g_head
                // matrix border above row 0
                assign h_top_in[r]  = '0;
                assign h_diag_in[r] = '0;
                assign e_top_in[r]  = '0;
                assign base_in[r]   = i_base;
                assign valid_in[r]  = i_base_valid;
                assign col_in[r]    = i_col;
            end else begin : g_link
                assign h_top_in[r]  = o_score[r-1];
                assign h_diag_in[r] = h_prev[r-1];
                assign e_top_in[r]  = e_q[r-1];
                assign base_in[r]   = base_q[r-1];
                assign valid_in[r]  = base_valid_q[r-1];
                assign col_in[r]    = o_col[r-1];
            end

            assign row_active[r] = read_len_t'(r) < i_read_len;

            sw_pe u_pe (
                .clk          (clk),
                .rst          (rst),
                .i_base       (base_in[r]),
                .i_read_base  (read_q[2*READ_MAX_LENGTH-1-2*r -: 2]),
                .i_base_valid (valid_in[r]),
                .i_row_active (row_active[r]),
                .i_clear      (i_load),
                .i_col        (col_in[r]),
                .i_h_top      (h_top_in[r]),
                .i_h_diag     (h_diag_in[r]),
                .i_e_top      (e_top_in[r]),
                .o_h          (o_score[r]),
                .o_h_prev     (h_prev[r]),
                .o_e          (e_q[r]),
                .o_base       (base_q[r]),
                .o_base_valid (base_valid_q[r]),
                .o_cell_valid (o_cell_valid[r]),
                .o_col        (o_col[r])
            );
        end
    endgenerate

endmodule

// ==== hw/ref_feeder.sv ====
// reference store; shifts out one base per feed cycle into the top row of the array
`timescale 1ns/1ps

module ref_feeder import sw_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  logic      i_load,
    input  logic      i_feed,
    input  ref_seq_t  i_ref_seq,
    input  ref_len_t  i_ref_len,
    output base_t     o_base,
    output logic      o_base_valid,
    output col_t      o_col
);

    ref_seq_t ref_sr;
    ref_len_t ref_len_q;
    ref_len_t sent;

    assign o_base       = ref_sr[2*REF_MAX_LENGTH-1 -: 2];
    assign o_base_valid = i_feed && (sent < ref_len_q);
    assign o_col        = col_t'(sent);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            sent      <= '0;
            ref_len_q <= '0;
        end else if (i_load) begin
            sent      <= '0;
            ref_len_q <= i_ref_len;
        end else if (o_base_valid) begin
            sent <= sent + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (i_load) begin
            ref_sr <= i_ref_seq;
        end else if (o_base_valid) begin
            ref_sr <= ref_sr << 2;
        end
    end

endmodule

// ==== hw/best_cell_select.sv ====
// keeps each row's best score, then scans the rows in order for the overall best cell
`timescale 1ns/1ps

module best_cell_select import sw_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       i_clear,
    input  logic       i_scan_start,
    input  read_len_t  i_read_len,
    input  score_t     i_score      [READ_MAX_LENGTH],
    input  logic       i_cell_valid [READ_MAX_LENGTH],
    input  col_t       i_col        [READ_MAX_LENGTH],
    output logic       o_scan_done,
    output score_t     o_score,
    output row_t       o_row,
    output col_t       o_col
);

    score_t    row_max [READ_MAX_LENGTH];
    col_t      row_col [READ_MAX_LENGTH];
    logic      scanning;
    row_t      scan_row;
    read_len_t last_row;

    assign last_row = i_read_len - 1'b1;

    // strict compare keeps the first column that reached the maximum
    always_ff @(posedge clk) begin
        for (int r = 0; r < READ_MAX_LENGTH; r++) begin
            if (i_clear) begin
                row_max[r] <= '0;
                row_col[r] <= '0;
            end else if (i_cell_valid[r] && (i_score[r] > row_max[r])) begin
                row_max[r] <= i_score[r];
                row_col[r] <= i_col[r];
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            scanning    <= 1'b0;
            scan_row    <= '0;
            o_scan_done <= 1'b0;
            o_score     <= '0;
            o_row       <= '0;
            o_col       <= '0;
        end else begin
            o_scan_done <= 1'b0;
            if (i_clear) begin
                scanning <= 1'b0;
                o_score  <= '0;
                o_row    <= '0;
                o_col    <= '0;
            end else if (i_scan_start) begin
                scanning <= 1'b1;
                scan_row <= '0;
            end else if (scanning) begin
                // earlier rows win ties
                if (row_max[scan_row] > o_score) begin
                    o_score <= row_max[scan_row];
                    o_row   <= scan_row;
                    o_col   <= row_col[scan_row];
                end
                if (read_len_t'(scan_row) == last_row) begin
                    scanning    <= 1'b0;
                    o_scan_done <= 1'b1;
                end else begin
                    scan_row <= scan_row + 1'b1;
                end
            end
        end
    end

endmodule

// ==== hw/sw_ctrl.sv ====
// job sequencer for the alignment engine; steps through load, compute, scan and result hold
`timescale 1ns/1ps

module sw_ctrl import sw_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        i_valid,
    input  logic        i_ready,
    input  ref_len_t    i_ref_len,
    input  read_len_t   i_read_len,
    input  logic        scan_done,
    output logic        o_ready,
    output logic        o_valid,
    output logic        o_load,
    output logic        o_feed,
    output logic        o_scan_start,
    output read_len_t   o_read_len
);

    ctrl_state_t state;
    step_t       step;
    step_t       calc_steps;
    ref_len_t    ref_len_q;
    read_len_t   read_len_q;
    logic        calc_last;

    // one anti-diagonal per cycle until the last cell leaves the bottom row
    assign calc_steps = step_t'(ref_len_q) + step_t'(read_len_q);
    assign calc_last  = (state == CALC) && (step == calc_steps - 1'b1);

    assign o_ready    = (state == IDLE);
    assign o_valid    = (state == DONE);
    assign o_load     = o_ready && i_valid;
    assign o_feed     = (state == CALC);
    assign o_read_len = read_len_q;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state        <= IDLE;
            step         <= '0;
            ref_len_q    <= '0;
            read_len_q   <= '0;
            o_scan_start <= 1'b0;
        end else begin
            o_scan_start <= calc_last;
            case (state)
                IDLE: begin
                    if (i_valid) begin
                        ref_len_q  <= i_ref_len;
                        read_len_q <= i_read_len;
                        state      <= LOAD;
                    end
                end
                LOAD: begin
                    step  <= '0;
                    state <= CALC;
                end
                CALC: begin
                    if (calc_last) begin
                        state <= SCAN;
                    end else begin
                        step <= step + 1'b1;
                    end
                end
                SCAN: begin
                    if (scan_done) begin
                        state <= DONE;
                    end
                end
                DONE: begin
                    // hold the result until the consumer takes it
                    if (i_ready) begin
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

endmodule

// ==== hw/sw_core.sv ====
// top of the local-alignment engine; controller, reference feeder, cell array and best-cell pick
`timescale 1ns/1ps

module sw_core import sw_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       i_valid,
    input  logic       i_ready,
    input  ref_seq_t   i_ref_seq,
    input  read_seq_t  i_read_seq,
    input  ref_len_t   i_ref_len,
    input  read_len_t  i_read_len,
    output logic       o_ready,
    output logic       o_valid,
    output score_t     o_score,
    output row_t       o_row,
    output col_t       o_col
);

    logic      load;
    logic      feed;
    logic      scan_start;
    logic      scan_done;
    read_len_t read_len;

    base_t     ref_base;
    logic      ref_base_valid;
    col_t      ref_col;

    score_t    cell_score [READ_MAX_LENGTH];
    logic      cell_valid [READ_MAX_LENGTH];
    col_t      cell_col   [READ_MAX_LENGTH];

    sw_ctrl u_ctrl (
        .clk          (clk),
        .rst          (rst),
        .i_valid      (i_valid),
        .i_ready      (i_ready),
        .i_ref_len    (i_ref_len),
        .i_read_len   (i_read_len),
        .scan_done    (scan_done),
        .o_ready      (o_ready),
        .o_valid      (o_valid),
        .o_load       (load),
        .o_feed       (feed),
        .o_scan_start (scan_start),
        .o_read_len   (read_len)
    );

    ref_feeder u_ref_feeder (
        .clk          (clk),
        .rst          (rst),
        .i_load       (load),
        .i_feed       (feed),
        .i_ref_seq    (i_ref_seq),
        .i_ref_len    (i_ref_len),
        .o_base       (ref_base),
        .o_base_valid (ref_base_valid),
        .o_col        (ref_col)
    );

    sw_pe_array u_pe_array (
        .clk          (clk),
        .rst          (rst),
        .i_load       (load),
        .i_read_seq   (i_read_seq),
        .i_read_len   (read_len),
        .i_base       (ref_base),
        .i_base_valid (ref_base_valid),
        .i_col        (ref_col),
        .o_score      (cell_score),
        .o_cell_valid (cell_valid),
        .o_col        (cell_col)
    );

    best_cell_select u_best (
        .clk          (clk),
        .rst          (rst),
        .i_clear      (load),
        .i_scan_start (scan_start),
        .i_read_len   (read_len),
        .i_score      (cell_score),
        .i_cell_valid (cell_valid),
        .i_col        (cell_col),
        .o_scan_done  (scan_done),
        .o_score      (o_score),
        .o_row        (o_row),
        .o_col        (o_col)
    );

endmodule

// ==== sim/sw_core_assert.sv ====
// protocol checks on the engine's job and result ports; bound into every sw_core instance
`timescale 1ns/1ps

module sw_core_assert import sw_pkg::*; (
    input logic   clk,
    input logic   rst,
    input logic   i_ready,
    input logic   o_ready,
    input logic   o_valid,
    input score_t o_score,
    input row_t   o_row,
    input col_t   o_col
);

    // engine never accepts a job while a result is pending
    a_ready_valid_excl: assert property (@(posedge clk) disable iff (rst)
        !(o_ready && o_valid))
        else $error("o_ready and o_valid are high in the same cycle");

    a_result_hold: assert property (@(posedge clk) disable iff (rst)
        (o_valid && !i_ready) |=>
            (o_valid && $stable(o_score) && $stable(o_row) && $stable(o_col)))
        else $error("result dropped or changed before i_ready");

    a_score_nonneg: assert property (@(posedge clk) disable iff (rst)
        o_score >= 0)
        else $error("o_score is negative");

endmodule

bind sw_core sw_core_assert i_assert (
    .clk     (clk),
    .rst     (rst),
    .i_ready (i_ready),
    .o_ready (o_ready),
    .o_valid (o_valid),
    .o_score (o_score),
    .o_row   (o_row),
    .o_col   (o_col)
);

// ==== sim/tb_sw_core.sv ====
// testbench for sw_core; random alignment jobs checked against a software model of the recurrence
`timescale 1ns/1ps

module tb_sw_core import sw_pkg::*; ();

    localparam int WAIT_LIMIT = 100;

    logic      clk;
    logic      rst;
    logic      i_valid;
    logic      i_ready;
    ref_seq_t  i_ref_seq;
    read_seq_t i_read_seq;
    ref_len_t  i_ref_len;
    read_len_t i_read_len;
    logic      o_ready;
    logic      o_valid;
    score_t    o_score;
    row_t      o_row;
    col_t      o_col;

    logic [31:0] rng;
    base_t       ref_b  [REF_MAX_LENGTH];
    base_t       read_b [READ_MAX_LENGTH];
    score_t      exp_score;
    row_t        exp_row;
    col_t        exp_col;

    sw_core i_dut (
        .clk        (clk),
        .rst        (rst),
        .i_valid    (i_valid),
        .i_ready    (i_ready),
        .i_ref_seq  (i_ref_seq),
        .i_read_seq (i_read_seq),
        .i_ref_len  (i_ref_len),
        .i_read_len (i_read_len),
        .o_ready    (o_ready),
        .o_valid    (o_valid),
        .o_score    (o_score),
        .o_row      (o_row),
        .o_col      (o_col)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // value in 0..n-1
    function automatic int pick(input int n);
        rng = xorshift32(rng);
        return int'(rng % 32'(n));
    endfunction

    function automatic int max3(input int a, input int b, input int c);
        int m;
        m = (b > a) ? b : a;
        return (c > m) ? c : m;
    endfunction

    task automatic stop_on_error();
        $display("Finished with errors");
        $fatal(1, "stopping at first error");
    endtask

    task automatic check_score(input score_t exp, input score_t act);
        if (act !== exp) begin
            $display("** Error at time %0t: o_score expected %0d, got %0d", $time, exp, act);
            stop_on_error();
        end
    endtask

    task automatic check_row(input row_t exp, input row_t act);
        if (act !== exp) begin
            $display("** Error at time %0t: o_row expected %0d, got %0d", $time, exp, act);
            stop_on_error();
        end
    endtask

    task automatic check_col(input col_t exp, input col_t act);
        if (act !== exp) begin
            $display("** Error at time %0t: o_col expected %0d, got %0d", $time, exp, act);
            stop_on_error();
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("** Error at time %0t: %s expected %b, got %b", $time, name, exp, act);
            stop_on_error();
        end
    endtask

    task automatic wait_ready();
        int n;
        n = 0;
        while (o_ready !== 1'b1) begin
            @(negedge clk);
            n++;
            if (n > WAIT_LIMIT) begin
                $display("timeout while waiting for o_ready to come back high");
                stop_on_error();
            end
        end
    endtask

    task automatic wait_valid();
        int n;
        n = 0;
        while (o_valid !== 1'b1) begin
            @(negedge clk);
            n++;
            if (n > WAIT_LIMIT) begin
                $display("timeout while waiting for o_valid after a job was accepted");
                stop_on_error();
            end
        end
    endtask

    task automatic fill_random();
        for (int j = 0; j < REF_MAX_LENGTH; j++) begin
            ref_b[j] = base_t'(pick(4));
        end
        for (int i = 0; i < READ_MAX_LENGTH; i++) begin
            read_b[i] = base_t'(pick(4));
        end
    endtask

    // full H, E, F matrices; best cell in row-major order, strict greater wins
    task automatic align_model(input int ref_len, input int read_len);
        int h [READ_MAX_LENGTH+1][REF_MAX_LENGTH+1];
        int e [READ_MAX_LENGTH+1][REF_MAX_LENGTH+1];
        int f [READ_MAX_LENGTH+1][REF_MAX_LENGTH+1];
        int sub;
        int best;
        for (int i = 0; i <= READ_MAX_LENGTH; i++) begin
            for (int j = 0; j <= REF_MAX_LENGTH; j++) begin
                h[i][j] = 0;
                e[i][j] = 0;
                f[i][j] = 0;
            end
        end
        best      = 0;
        exp_score = '0;
        exp_row   = '0;
        exp_col   = '0;
        for (int i = 1; i <= read_len; i++) begin
            for (int j = 1; j <= ref_len; j++) begin
                sub = (read_b[i-1] == ref_b[j-1]) ? int'(MATCH_SCORE) : int'(MISMATCH_SCORE);
                e[i][j] = max3(0, h[i-1][j] + int'(GAP_OPEN), e[i-1][j] + int'(GAP_EXTEND));
                f[i][j] = max3(0, h[i][j-1] + int'(GAP_OPEN), f[i][j-1] + int'(GAP_EXTEND));
                h[i][j] = max3(h[i-1][j-1] + sub, e[i][j], f[i][j]);
                if (h[i][j] > best) begin
                    best      = h[i][j];
                    exp_score = score_t'(best);
                    exp_row   = row_t'(i - 1);
                    exp_col   = col_t'(j - 1);
                end
            end
        end
    endtask

    task automatic run_job(input int ref_len, input int read_len, input int hold);
        align_model(ref_len, read_len);
        wait_ready();
        for (int j = 0; j < REF_MAX_LENGTH; j++) begin
            i_ref_seq[2*REF_MAX_LENGTH-1-2*j -: 2] = ref_b[j];
        end
        for (int i = 0; i < READ_MAX_LENGTH; i++) begin
            i_read_seq[2*READ_MAX_LENGTH-1-2*i -: 2] = read_b[i];
        end
        i_ref_len  = ref_len_t'(ref_len);
        i_read_len = read_len_t'(read_len);
        i_valid    = 1'b1;
        @(negedge clk);
        // job was taken on the last edge; junk on the inputs must not matter now
        i_valid    = 1'b0;
        rng        = xorshift32(rng);
        i_ref_seq  = ref_seq_t'(rng);
        i_read_seq = read_seq_t'(rng >> 7);
        i_ref_len  = ref_len_t'(rng >> 3);
        i_read_len = read_len_t'(rng >> 11);
        wait_valid();
        check_score(exp_score, o_score);
        check_row(exp_row, o_row);
        check_col(exp_col, o_col);
        repeat (hold) begin
            @(negedge clk);
            check_flag("o_valid", 1'b1, o_valid);
            check_score(exp_score, o_score);
            check_row(exp_row, o_row);
            check_col(exp_col, o_col);
        end
        i_ready = 1'b1;
        @(negedge clk);
        i_ready = 1'b0;
        check_flag("o_valid", 1'b0, o_valid);
        check_flag("o_ready", 1'b1, o_ready);
    endtask

    initial begin
        int    ref_len;
        int    read_len;
        int    offset;
        int    hold;
        base_t b;
        rng         = 32'd10;
        rst         = 1'b1;
        i_valid     = 1'b0;
        i_ready     = 1'b0;
        i_ref_seq   = '0;
        i_read_seq  = '0;
        i_ref_len   = '0;
        i_read_len  = '0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        check_flag("o_ready", 1'b1, o_ready);
        check_flag("o_valid", 1'b0, o_valid);

        // full lengths
        for (int k = 0; k < 20; k++) begin
            fill_random();
            hold = pick(8);
            run_job(REF_MAX_LENGTH, READ_MAX_LENGTH, hold);
        end

        // random lengths, tails beyond each length stay random
        for (int k = 0; k < 40; k++) begin
            fill_random();
            ref_len  = 1 + pick(REF_MAX_LENGTH);
            read_len = 1 + pick(READ_MAX_LENGTH);
            hold     = pick(8);
            run_job(ref_len, read_len, hold);
        end

        // read base absent from the reference
        for (int k = 0; k < 5; k++) begin
            b = base_t'(pick(4));
            for (int i = 0; i < READ_MAX_LENGTH; i++) begin
                read_b[i] = b;
            end
            for (int j = 0; j < REF_MAX_LENGTH; j++) begin
                ref_b[j] = base_t'(int'(b) + 1 + pick(3));
            end
            ref_len  = 1 + pick(REF_MAX_LENGTH);
            read_len = 1 + pick(READ_MAX_LENGTH);
            run_job(ref_len, read_len, 2);
            check_score('0, o_score);
            check_row('0, o_row);
            check_col('0, o_col);
        end

        // exact copy of the read somewhere in the reference
        for (int k = 0; k < 10; k++) begin
            fill_random();
            read_len = 1 + pick(READ_MAX_LENGTH);
            ref_len  = read_len + pick(REF_MAX_LENGTH - read_len + 1);
            offset   = pick(ref_len - read_len + 1);
            for (int i = 0; i < read_len; i++) begin
                ref_b[offset + i] = read_b[i];
            end
            hold = pick(4);
            run_job(ref_len, read_len, hold);
            check_score(score_t'(2 * read_len), o_score);
            check_row(row_t'(read_len - 1), o_row);
        end

        $display("Finished with no errors");
        $finish;
    end

endmodule

// ==== filelist.f ====
hw/sw_pkg.sv
hw/sw_pe.sv
hw/sw_pe_array.sv
hw/ref_feeder.sv
hw/best_cell_select.sv
hw/sw_ctrl.sv
hw/sw_core.sv
sim/sw_core_assert.sv
sim/tb_sw_core.sv

// ==== Makefile ====
TOP := tb_sw_core
LOG := sim.log

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -Wno-fatal -f filelist.f --top-module $(TOP) -o $(TOP)

run: build
	./obj_dir/$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "Finished with no errors" $(LOG)

lint:
	verilator --lint-only --timing -Wall -f filelist.f --top-module $(TOP)

clean:
	rm -rf obj_dir $(LOG)
